//--- board_pkg.sv
package board_pkg;

	// 16-bit instruction word, opcode on top and operand below
	localparam int OPCODE_W  = 4;
	localparam int OPERAND_W = 12;
	localparam int INSTR_W   = OPCODE_W + OPERAND_W;

	// run control, HALTED is the state after reset
	typedef enum logic [1:0] {
		RUN    = 2'd0,
		HALTED = 2'd1,
		STEP   = 2'd2
	} run_state_t;

	// core phases, WRITEBACK only for loads
	typedef enum logic [1:0] {
		FETCH     = 2'd0,
		EXEC      = 2'd1,
		WRITEBACK = 2'd2
	} core_state_t;

	// any code not listed here runs as a nop
	typedef enum logic [OPCODE_W-1:0] {
		OP_ADDI  = 4'h1,
		OP_LOAD  = 4'h2,
		OP_STORE = 4'h3,
		OP_JUMP  = 4'h4
	} opcode_t;

endpackage

//--- mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if #(
	parameter int ADDR_W = 8,
	parameter int DATA_W = 16
) ();

	logic [ADDR_W-1:0] addr;
	logic              wr_ena;
	logic [DATA_W-1:0] wr_data;
	// valid one cycle after addr
	logic [DATA_W-1:0] rd_data;

	modport master (output addr, output wr_ena, output wr_data, input rd_data);

	modport memory (input addr, input wr_ena, input wr_data, output rd_data);

endinterface

//--- debouncer.sv
`timescale 1ns/1ps

module debouncer #(
	parameter int   CYCLES        = 1_000_000,
	parameter int   COUNTER_WIDTH = $clog2(CYCLES + 1),
	parameter logic RESET_VALUE   = 1'b1
) (
	input  logic cclk,
	input  logic reset,
	input  logic bouncy,
	output logic debounced
);

	// cycles the input has differed from the stable level
	logic [COUNTER_WIDTH-1:0] count;

	always_ff @(posedge cclk) begin
		if (reset) begin
			debounced <= RESET_VALUE;
			count <= '0;
		end else if (bouncy == debounced) begin
			// glitch ended, start over
			count <= '0;
		end else if (count == COUNTER_WIDTH'(CYCLES - 1)) begin
			// held long enough, take the new level
			debounced <= bouncy;
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

//--- one_shot.sv
`timescale 1ns/1ps

module one_shot #(
	parameter int PULSE_WIDTH   = 1,
	parameter int DEAD_TIME     = 50_000_000,
	parameter int COUNTER_WIDTH = $clog2(PULSE_WIDTH + DEAD_TIME + 1)
) (
	input  logic cclk,
	input  logic reset,
	input  logic trigger,
	output logic pulse,
	output logic one_shot
);

	logic                     trigger_q;
	logic                     rise;
	// counts down through the pulse and then the dead time
	logic [COUNTER_WIDTH-1:0] count;

	assign rise = trigger & ~trigger_q;

	always_ff @(posedge cclk) begin
		if (reset) begin
			trigger_q <= 1'b0;
			count <= '0;
		end else begin
			trigger_q <= trigger;
			if (count != '0) begin
				count <= count - 1'b1;
			end else if (rise) begin
				count <= COUNTER_WIDTH'(PULSE_WIDTH + DEAD_TIME);
			end
		end
	end

	// top PULSE_WIDTH counts are the pulse itself
	assign pulse = count > COUNTER_WIDTH'(DEAD_TIME);

	// busy until the dead time runs out, a held button never retriggers
	assign one_shot = count != '0;

endmodule

//--- run_control.sv
`timescale 1ns/1ps

module run_control #(
	parameter int ADDR_W = 8
) (
	input  logic              cclk,
	input  logic              reset,
	input  logic              step_mode,
	input  logic              step_pulse,
	input  logic              instr_done,
	input  logic [ADDR_W-1:0] pc,
	input  logic              break_ena,
	input  logic [ADDR_W-1:0] break_addr,
	output logic              core_ena,
	output logic              halted
);

	board_pkg::run_state_t state;
	// set on continue so we can leave a breakpoint address
	logic                  skip_break;
	logic                  break_hit;

	// pc already shows the next instruction at instr_done
	assign break_hit = break_ena & ~skip_break & (pc == break_addr);

	always_ff @(posedge cclk) begin
		if (reset) begin
			state <= board_pkg::HALTED;
			skip_break <= 1'b0;
		end else begin
			case (state)
				board_pkg::HALTED: begin
					if (step_pulse) begin
						if (step_mode) begin
							state <= board_pkg::STEP;
						end else begin
							state <= board_pkg::RUN;
							skip_break <= 1'b1;
						end
					end
				end
				board_pkg::STEP: begin
					if (instr_done) state <= board_pkg::HALTED;
				end
				board_pkg::RUN: begin
					if (instr_done) begin
						skip_break <= 1'b0;
						if (step_mode || break_hit) state <= board_pkg::HALTED;
					end
				end
				default: state <= board_pkg::HALTED;
			endcase
		end
	end

	// ena only drops on an instruction boundary
	assign core_ena = (state == board_pkg::RUN) || (state == board_pkg::STEP);
	assign halted = state == board_pkg::HALTED;

endmodule

//--- dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
	parameter int ADDR_W = 8,
	parameter int DATA_W = 16
) (
	input logic cclk,
	mem_port_if.memory port0,
	mem_port_if.memory port1
);

	logic [DATA_W-1:0] words [0:2**ADDR_W-1];

	// port 1 is written last, so the host wins a same-address collision
	always_ff @(posedge cclk) begin
		if (port0.wr_ena) begin
			words[port0.addr] <= port0.wr_data;
		end
		if (port1.wr_ena) begin
			words[port1.addr] <= port1.wr_data;
		end
	end

	// synchronous reads, old data on a same-cycle write
	always_ff @(posedge cclk) begin
		port0.rd_data <= words[port0.addr];
	end

	always_ff @(posedge cclk) begin
		port1.rd_data <= words[port1.addr];
	end

endmodule

//--- accum_core.sv
`timescale 1ns/1ps

module accum_core #(
	parameter int ADDR_W = 8,
	parameter int DATA_W = 16
) (
	input  logic              cclk,
	input  logic              reset,
	input  logic              ena,
	mem_port_if.master        mem,
	output logic [ADDR_W-1:0] pc,
	output logic [DATA_W-1:0] acc,
	output logic              instr_done
);

	board_pkg::core_state_t         state;
	board_pkg::core_state_t         state_next;
	board_pkg::opcode_t             opcode;
	logic [board_pkg::OPERAND_W-1:0] operand;
	logic [ADDR_W-1:0]              pc_q;
	logic [ADDR_W-1:0]              pc_next;
	logic [DATA_W-1:0]              acc_q;
	logic [DATA_W-1:0]              acc_next;

	// instruction word arrives during EXEC
	assign opcode = board_pkg::opcode_t'(mem.rd_data[board_pkg::INSTR_W-1 -: board_pkg::OPCODE_W]);
	assign operand = mem.rd_data[board_pkg::OPERAND_W-1:0];

	always_comb begin
		mem.addr = pc_q;
		mem.wr_ena = 1'b0;
		mem.wr_data = acc_q;
		if (state == board_pkg::EXEC &&
				(opcode == board_pkg::OP_LOAD || opcode == board_pkg::OP_STORE)) begin
			mem.addr = operand[ADDR_W-1:0];
			mem.wr_ena = ena && (opcode == board_pkg::OP_STORE);
		end
	end

	always_comb begin
		state_next = state;
		pc_next = pc_q;
		acc_next = acc_q;
		instr_done = 1'b0;
		if (ena) begin
			case (state)
				board_pkg::FETCH: state_next = board_pkg::EXEC;
				board_pkg::EXEC: begin
					state_next = board_pkg::FETCH;
					pc_next = pc_q + 1'b1;
					instr_done = 1'b1;
					case (opcode)
						board_pkg::OP_ADDI: acc_next = acc_q + DATA_W'(operand);
						board_pkg::OP_LOAD: begin
							// one more cycle for the read data
							state_next = board_pkg::WRITEBACK;
							instr_done = 1'b0;
						end
						board_pkg::OP_JUMP: pc_next = operand[ADDR_W-1:0];
						default: ;
					endcase
				end
				board_pkg::WRITEBACK: begin
					acc_next = mem.rd_data;
					state_next = board_pkg::FETCH;
					instr_done = 1'b1;
				end
				default: state_next = board_pkg::FETCH;
			endcase
		end
	end

	always_ff @(posedge cclk) begin
		if (reset) begin
			state <= board_pkg::FETCH;
			pc_q <= '0;
			acc_q <= '0;
		end else begin
			state <= state_next;
			pc_q <= pc_next;
			acc_q <= acc_next;
		end
	end

	// next pc, so run control sees where the core goes at instr_done
	assign pc = pc_next;
	assign acc = acc_q;

endmodule

//--- board_top.sv
`timescale 1ns/1ps

module board_top #(
	parameter int ADDR_W          = 8,
	parameter int DATA_W          = 16,
	parameter int DEBOUNCE_CYCLES = 1_000_000,
	parameter int DEAD_TIME       = 50_000_000,
	parameter int PULSE_WIDTH     = 1
) (
	input  logic              cclk,
	input  logic              reset,
	input  logic              mode_switch,
	input  logic              step_button,
	input  logic              break_ena,
	input  logic [ADDR_W-1:0] break_addr,
	input  logic [ADDR_W-1:0] dbg_addr,
	input  logic              dbg_wr_ena,
	input  logic [DATA_W-1:0] dbg_wr_data,
	output logic [DATA_W-1:0] dbg_rd_data,
	output logic [ADDR_W-1:0] pc,
	output logic [DATA_W-1:0] acc,
	output logic              halted,
	output logic              step_led
);

	logic step_mode, step_pulse, step_busy;
	logic core_ena, instr_done;

	mem_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) core_port ();
	mem_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) host_port ();

	// debug host drives port 1 directly
	assign host_port.addr = dbg_addr;
	assign host_port.wr_ena = dbg_wr_ena;
	assign host_port.wr_data = dbg_wr_data;
	assign dbg_rd_data = host_port.rd_data;

	// comes up in step mode
	debouncer #(
		.CYCLES(DEBOUNCE_CYCLES),
		.COUNTER_WIDTH($clog2(DEBOUNCE_CYCLES + 1)),
		.RESET_VALUE(1'b1)
	) mode_debounce (
		.cclk(cclk), .reset(reset), .bouncy(mode_switch), .debounced(step_mode)
	);

	// dead time also takes care of button bounce
	one_shot #(
		.PULSE_WIDTH(PULSE_WIDTH),
		.DEAD_TIME(DEAD_TIME),
		.COUNTER_WIDTH($clog2(PULSE_WIDTH + DEAD_TIME + 1))
	) step_one_shot (
		.cclk(cclk), .reset(reset), .trigger(step_button), .pulse(step_pulse),
		.one_shot(step_busy)
	);

	run_control #(.ADDR_W(ADDR_W)) run_ctrl (
		.cclk(cclk), .reset(reset), .step_mode(step_mode), .step_pulse(step_pulse),
		.instr_done(instr_done), .pc(pc), .break_ena(break_ena), .break_addr(break_addr),
		.core_ena(core_ena), .halted(halted)
	);

	accum_core #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) core (
		.cclk(cclk), .reset(reset), .ena(core_ena), .mem(core_port.master),
		.pc(pc), .acc(acc), .instr_done(instr_done)
	);

	dual_port_ram #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) ram (
		.cclk(cclk), .port0(core_port.memory), .port1(host_port.memory)
	);

	// lit while a step is pending or when free running
	assign step_led = step_busy | ~step_mode;

endmodule

//--- tb_board_top.sv
`timescale 1ns/1ps

module tb_board_top;

	localparam int RESET_CYCLES = 16;
	localparam int DEAD_TIME = 30;
	localparam int PROG_LEN = 7;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + PROG_LEN * DEAD_TIME * 2 * 4 + 2000;

	logic cclk = 1'b0;
	logic reset, mode_switch, step_button, break_ena, dbg_wr_ena, halted, step_led;
	logic count_clear;
	logic [7:0] break_addr, dbg_addr, pc;
	logic [15:0] dbg_wr_data, dbg_rd_data, acc;
	logic [15:0] model_mem [0:255];
	logic [7:0] m_pc;
	logic [15:0] m_acc;
	int errors, prop_errors, done_count;

	board_top #(.DEBOUNCE_CYCLES(8), .DEAD_TIME(DEAD_TIME)) dut_i (.*);

	always #20 cclk = ~cclk;

	// instructions finished since the last clear
	always @(posedge cclk) begin
		if (count_clear) done_count <= 0;
		else if (dut_i.instr_done) done_count <= done_count + 1;
	end

	// step_led still lit in the last cycle of the dead time
	assert property (@(posedge cclk) disable iff (reset)
			$past(dut_i.step_pulse, DEAD_TIME) |-> step_led)
		else begin
			prop_errors++;
			$display("Fail at %0t: step_led expected 1 got 0", $time);
		end

	// a halted core must not move
	assert property (@(posedge cclk) disable iff (reset) halted && $past(halted) |-> $stable(pc))
		else begin
			prop_errors++;
			$display("Fail at %0t: pc changed while halted", $time);
		end

	task automatic tick(int n = 1);
		repeat (n) begin
			@(posedge cclk);
			#2;
		end
	endtask

	task automatic check_value(string name, logic [15:0] exp, logic [15:0] act);
		assert (exp === act) else begin
			errors++;
			$display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic model_step();
		logic [15:0] word;
		word = model_mem[m_pc];
		m_pc = m_pc + 8'd1;
		case (word[15:12])
			board_pkg::OP_ADDI: m_acc = m_acc + {4'h0, word[11:0]};
			board_pkg::OP_LOAD: m_acc = model_mem[word[7:0]];
			board_pkg::OP_STORE: model_mem[word[7:0]] = m_acc;
			board_pkg::OP_JUMP: m_pc = word[7:0];
			default: ;
		endcase
	endtask

	task automatic wait_halted(logic level);
		int n;
		for (n = 0; n < 400 && halted !== level; n++) tick();
		if (halted !== level) begin
			errors++;
			$display("timed out waiting for halted to become %b", level);
		end
	endtask

	// step mode only, step_led drops once the dead time is over
	task automatic wait_idle();
		int n;
		for (n = 0; n < 100 && step_led; n++) tick();
		if (step_led) begin
			errors++;
			$display("timed out waiting for step_led to go low");
		end
	endtask

	task automatic press();
		step_button = 1'b1;
		tick(2);
		step_button = 1'b0;
	endtask

	task automatic host_read(logic [7:0] addr, logic [15:0] exp, string name);
		dbg_addr = addr;
		dbg_wr_ena = 1'b0;
		tick();
		check_value(name, exp, dbg_rd_data);
	endtask

	task automatic single_step();
		wait_idle();
		press();
		wait_halted(1'b0);
		wait_halted(1'b1);
		model_step();
		check_value("pc", {8'h0, m_pc}, {8'h0, pc});
		check_value("acc", m_acc, acc);
	endtask

	task automatic run_to_halt(logic use_mode);
		int i;
		// let the last press's dead time run out
		tick(DEAD_TIME);
		count_clear = 1'b1;
		tick();
		count_clear = 1'b0;
		press();
		wait_halted(1'b0);
		if (use_mode) begin
			tick(150);
			mode_switch = 1'b1;
		end
		wait_halted(1'b1);
		for (i = 0; i < done_count; i++) model_step();
		check_value("pc", {8'h0, m_pc}, {8'h0, pc});
		check_value("acc", m_acc, acc);
	endtask

	initial begin
		int i;
		{reset, mode_switch, step_button, break_ena, dbg_wr_ena, count_clear} = 6'b110001;
		{break_addr, dbg_addr, dbg_wr_data} = '0;
		{errors, prop_errors, m_pc, m_acc} = '0;
		void'($urandom(32'hea64));
		// loop of adds, a store, a load back and a jump to 0
		model_mem[0] = {board_pkg::OP_ADDI, 12'($urandom)};
		model_mem[1] = {board_pkg::OP_STORE, 12'h080};
		model_mem[2] = {board_pkg::OP_ADDI, 12'($urandom)};
		model_mem[3] = {board_pkg::OP_LOAD, 12'h080};
		model_mem[4] = {board_pkg::OP_ADDI, 12'($urandom)};
		model_mem[5] = {board_pkg::OP_STORE, 12'h081};
		model_mem[6] = {board_pkg::OP_JUMP, 12'h000};
		tick(RESET_CYCLES);
		reset = 1'b0;
		check_value("halted", 16'd1, {15'd0, halted});
		for (i = 0; i < PROG_LEN; i++) begin
			dbg_addr = 8'(i);
			dbg_wr_data = model_mem[i];
			dbg_wr_ena = 1'b1;
			tick();
			host_read(8'(i), model_mem[i], "dbg_rd_data");
		end
		for (i = 0; i < 4; i++) single_step();
		// second press inside the dead time
		press();
		tick(8);
		check_value("halted", 16'd1, {15'd0, halted});
		check_value("step_led", 16'd1, {15'd0, step_led});
		check_value("pc", {8'h0, m_pc}, {8'h0, pc});
		single_step();
		// short glitch on the mode switch, step mode must hold throughout
		wait_idle();
		mode_switch = 1'b0;
		for (i = 0; i < 15; i++) begin
			if (i == 3) mode_switch = 1'b1;
			tick();
			check_value("step_led", 16'd0, {15'd0, step_led});
		end
		single_step();
		mode_switch = 1'b0;
		tick(12);
		run_to_halt(1'b1);
		host_read(8'h80, model_mem[8'h80], "mem[80]");
		host_read(8'h81, model_mem[8'h81], "mem[81]");
		break_ena = 1'b1;
		break_addr = 8'd5;
		mode_switch = 1'b0;
		tick(12);
		run_to_halt(1'b0);
		check_value("pc", 16'd5, {8'h0, pc});
		run_to_halt(1'b0);
		check_value("pc", 16'd5, {8'h0, pc});
		check_value("done_count", 16'd7, 16'(done_count));
		$display("errors: %0d", errors + prop_errors);
		if (errors + prop_errors == 0) $display("*** TEST PASSED ***");
		else $display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		#(40 * WATCHDOG_CYCLES);
		$display("watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- board.f
board_pkg.sv
mem_port_if.sv
debouncer.sv
one_shot.sv
run_control.sv
dual_port_ram.sv
accum_core.sv
board_top.sv
tb_board_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f board.f --top-module tb_board_top -o sim_board
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_board > run.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error"
	exit 1
fi

cat run.log
if grep -qF "*** TEST PASSED ***" run.log; then
	exit 0
fi
exit 1
